// ==== list.f ====
+incdir+rtl
rtl/touch_pkg.sv
rtl/host_cmd_decoder.sv
rtl/mpr_config_rom.sv
rtl/mpr_sequencer.sv
rtl/host_frame_builder.sv
rtl/touch_core_top.sv
verification/mpr121_bus_model.sv
verification/touch_core_tb.sv

// ==== rtl/host_cmd_decoder.sv ====
// host command decoder: run mode level and register read requests
`timescale 1ns/1ps

module host_cmd_decoder (
	input  logic                  i_CLK,
	input  logic                  i_RST,
	input  touch_pkg::host_word_t i_rx_data,
	input  logic                  i_rx_valid,
	output logic                  o_run_mode,
	output logic                  o_rd_req,
	output touch_pkg::mpr_addr_t  o_rd_addr
);
	import touch_pkg::*;

	host_word_t r_rx_word; // last accepted word
	host_cmd_e  w_cmd;

	assign w_cmd = host_cmd_e'(i_rx_data[15:8]);

	// ==================================================
	// command capture
	// ==================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_run_mode <= 1'b0;
			o_rd_req   <= 1'b0;
		end else begin
			o_rd_req <= 1'b0; // strobe
			if (i_rx_valid) begin
				case (w_cmd)
					HOST_CMD_RUN: begin
						o_run_mode <= 1'b1;
					end
					HOST_CMD_STOP: begin
						o_run_mode <= 1'b0;
					end
					HOST_CMD_READ_REG: begin
						// reads are refused while polling
						o_rd_req <= ~o_run_mode;
					end
					default: begin
						// unknown codes dropped
					end
				endcase
			end
		end
	end

	// argument kept for the read request
	always_ff @(posedge i_CLK) begin
		if (i_rx_valid) begin
			r_rx_word <= i_rx_data;
		end
	end

	assign o_rd_addr = r_rx_word[7:0];

endmodule

// ==== rtl/host_frame_builder.sv ====
// host frame builder: pending touch and register frames, issued under UART ready
`timescale 1ns/1ps
`include "touch_params.svh"

module host_frame_builder (
	input  logic                   i_CLK,
	input  logic                   i_RST,
	input  logic                   i_touch_valid,
	input  logic [15:0]            i_status_word,
	input  logic                   i_reg_valid,
	input  touch_pkg::mpr_addr_t   i_reg_addr,
	input  touch_pkg::mpr_data_t   i_reg_data,
	input  logic                   i_tx_ready,
	output touch_pkg::uart_frame_t o_tx_data,
	output logic                   o_tx_valid
);
	import touch_pkg::*;

	logic        r_touch_pend;
	logic        r_reg_pend;
	logic [15:0] r_status_word;
	mpr_addr_t   r_reg_addr;
	mpr_data_t   r_reg_data;
	uart_frame_t w_touch_frame;
	uart_frame_t w_reg_frame;
	logic        w_send_touch;
	logic        w_send_reg;

	// touch first, register frame only when no touch waits
	assign w_send_touch = i_tx_ready & r_touch_pend;
	assign w_send_reg   = i_tx_ready & r_reg_pend & ~r_touch_pend;

	// ==================================================
	// pending flags
	// ==================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_touch_pend <= 1'b0;
			r_reg_pend   <= 1'b0;
		end else begin
			if (i_touch_valid) r_touch_pend <= 1'b1; // new status beats the send
			else if (w_send_touch) r_touch_pend <= 1'b0;
			if (i_reg_valid) r_reg_pend <= 1'b1;
			else if (w_send_reg) r_reg_pend <= 1'b0;
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_touch_valid) r_status_word <= i_status_word; // overwrite unsent
		if (i_reg_valid) begin
			r_reg_addr <= i_reg_addr;
			r_reg_data <= i_reg_data;
		end
	end

	// ==================================================
	// frame assembly
	// ==================================================
	assign w_touch_frame = {`TAG_TOUCH, r_status_word, 56'b0};
	assign w_reg_frame   = {`TAG_REG, r_reg_addr, r_reg_data, 56'b0};

	assign o_tx_valid = w_send_touch | w_send_reg;
	assign o_tx_data  = w_send_touch ? w_touch_frame :
		w_send_reg ? w_reg_frame : '0;

endmodule

// ==== rtl/mpr_config_rom.sv ====
// MPR121 setup table: recommended filter and debounce register/value pairs
`timescale 1ns/1ps
`include "touch_params.svh"

module mpr_config_rom (
	input  touch_pkg::init_step_t i_step,
	output touch_pkg::mpr_addr_t  o_addr,
	output touch_pkg::mpr_data_t  o_data
);

	// {address, value}, written in this order
	localparam logic [15:0] SETUP_TABLE [`MPR_INIT_COUNT] = '{
		16'h2B01, // MHD rising
		16'h2C01, // NHD rising
		16'h2D0E, // NCL rising
		16'h2E00, // FDL rising
		16'h2F01, // MHD falling
		16'h3005, // NHD falling
		16'h3101, // NCL falling
		16'h3200, // FDL falling
		16'h3300, // NHD touched
		16'h3400, // NCL touched
		16'h3500, // FDL touched
		16'h5B00, // debounce
		16'h5C10, // CDC config
		16'h5D20  // CDT config
	};

	logic [15:0] w_pair;

	always_comb begin
		if (i_step < 4'(`MPR_INIT_COUNT)) begin
			w_pair = SETUP_TABLE[i_step];
		end else begin
			w_pair = 16'h0000; // past the end
		end
	end

	assign o_addr = w_pair[15:8];
	assign o_data = w_pair[7:0];

endmodule

// ==== rtl/mpr_sequencer.sv ====
// MPR121 bus sequencer: setup writes, run/stop, touch status polling, register reads
`timescale 1ns/1ps
`include "touch_params.svh"

module mpr_sequencer (
	input  logic                     i_CLK,
	input  logic                     i_RST,
	input  logic                     i_run_mode,
	input  logic                     i_rd_req,
	input  touch_pkg::mpr_addr_t     i_rd_addr,
	input  logic                     i_init_done,
	input  logic                     i_busy,
	input  logic                     i_fail,
	input  touch_pkg::mpr_data_t     i_rd_data,
	output touch_pkg::init_step_t    o_init_step,
	input  touch_pkg::mpr_addr_t     i_rom_addr,
	input  touch_pkg::mpr_data_t     i_rom_data,
	output touch_pkg::mpr_addr_t     o_reg_addr,
	output touch_pkg::mpr_data_t     o_wr_data,
	output logic                     o_wr_en,
	output logic                     o_rd_en,
	output touch_pkg::touch_status_t o_touch_status,
	output logic                     o_touch_valid,
	output logic [15:0]              o_status_word,
	output logic                     o_reg_valid,
	output touch_pkg::mpr_addr_t     o_reg_addr_echo,
	output touch_pkg::mpr_data_t     o_reg_data,
	output logic                     o_chip_set,
	output logic                     o_run_set,
	output logic                     o_error
);
	import touch_pkg::*;

	typedef enum logic [2:0] {
		ST_WAIT_INIT,
		ST_SETUP,
		ST_IDLE,
		ST_BUS_EN,
		ST_BUS_ACK,
		ST_BUS_DONE,
		ST_HALT
	} seq_state_e;

	// what the current bus transaction is for
	typedef enum logic [2:0] {
		OP_SETUP,
		OP_RUN,
		OP_STOP,
		OP_READ,
		OP_POLL_LO,
		OP_POLL_HI
	} seq_op_e;

	seq_state_e r_state;
	seq_op_e    r_op;
	init_step_t r_step;
	mpr_data_t  r_touch_lo; // status 0x00 held until 0x01 arrives
	logic       w_op_read;

	assign w_op_read   = (r_op == OP_READ) || (r_op == OP_POLL_LO) || (r_op == OP_POLL_HI);
	assign o_init_step = r_step;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state         <= ST_WAIT_INIT;
			r_op            <= OP_SETUP;
			r_step          <= '0;
			r_touch_lo      <= '0;
			o_reg_addr      <= '0;
			o_wr_data       <= '0;
			o_wr_en         <= 1'b0;
			o_rd_en         <= 1'b0;
			o_touch_status  <= '0;
			o_touch_valid   <= 1'b0;
			o_status_word   <= '0;
			o_reg_valid     <= 1'b0;
			o_reg_addr_echo <= '0;
			o_reg_data      <= '0;
			o_chip_set      <= 1'b0;
			o_run_set       <= 1'b0;
			o_error         <= 1'b0;
		end else begin
			// strobes
			o_wr_en       <= 1'b0;
			o_rd_en       <= 1'b0;
			o_touch_valid <= 1'b0;
			o_reg_valid   <= 1'b0;

			case (r_state)
				ST_WAIT_INIT: begin
					if (i_init_done) r_state <= ST_SETUP; // engine ready
				end

				ST_SETUP: begin
					o_reg_addr <= i_rom_addr;
					o_wr_data  <= i_rom_data;
					r_op       <= OP_SETUP;
					r_state    <= ST_BUS_EN;
				end

				// ==================================================
				// idle dispatch, also the poll boundary
				// ==================================================
				ST_IDLE: begin
					if (i_run_mode && !o_run_set) begin
						o_reg_addr <= `MPR_ELE_CONFIG_REG;
						o_wr_data  <= `MPR_ELE_RUN;
						r_op       <= OP_RUN;
						r_state    <= ST_BUS_EN;
					end else if (!i_run_mode && o_run_set) begin
						o_reg_addr <= `MPR_ELE_CONFIG_REG;
						o_wr_data  <= `MPR_ELE_STOP;
						r_op       <= OP_STOP;
						r_state    <= ST_BUS_EN;
					end else if (o_run_set) begin
						o_reg_addr <= `MPR_TOUCH0_REG; // next poll pair
						o_wr_data  <= '0;
						r_op       <= OP_POLL_LO;
						r_state    <= ST_BUS_EN;
					end else if (i_rd_req) begin
						o_reg_addr      <= i_rd_addr;
						o_wr_data       <= '0;
						o_reg_addr_echo <= i_rd_addr;
						r_op            <= OP_READ;
						r_state         <= ST_BUS_EN;
					end
				end

				// ==================================================
				// shared bus handshake
				// ==================================================
				ST_BUS_EN: begin
					// address settled last cycle
					o_rd_en <= w_op_read;
					o_wr_en <= ~w_op_read;
					r_state <= ST_BUS_ACK;
				end

				ST_BUS_ACK: begin
					if (i_busy) r_state <= ST_BUS_DONE; // engine took it
				end

				ST_BUS_DONE: begin
					if (!i_busy) begin
						if (i_fail) begin
							o_error <= 1'b1;
							r_state <= ST_HALT;
						end else begin
							case (r_op)
								OP_SETUP: begin
									if (r_step == 4'(`MPR_INIT_COUNT - 1)) begin
										o_chip_set <= 1'b1;
										r_state    <= ST_IDLE;
									end else begin
										r_step  <= r_step + 4'd1;
										r_state <= ST_SETUP;
									end
								end
								OP_RUN: begin
									o_run_set <= 1'b1;
									r_state   <= ST_IDLE;
								end
								OP_STOP: begin
									o_run_set <= 1'b0;
									r_state   <= ST_IDLE;
								end
								OP_READ: begin
									o_reg_data  <= i_rd_data;
									o_reg_valid <= 1'b1;
									r_state     <= ST_IDLE;
								end
								OP_POLL_LO: begin
									r_touch_lo <= i_rd_data;
									o_reg_addr <= `MPR_TOUCH1_REG; // straight to high byte
									r_op       <= OP_POLL_HI;
									r_state    <= ST_BUS_EN;
								end
								default: begin
									// pair complete, one update
									o_touch_status <= {i_rd_data[3:0], r_touch_lo};
									o_status_word  <= {4'b0, i_rd_data[3:0], r_touch_lo};
									o_touch_valid  <= 1'b1;
									r_state        <= ST_IDLE;
								end
							endcase
						end
					end
				end

				ST_HALT: begin
					r_state <= ST_HALT; // until reset
				end

				default: begin
					r_state <= ST_HALT;
				end
			endcase
		end
	end

endmodule

// ==== rtl/touch_core_top.sv ====
// top level of the MPR121 front end: decoder, sequencer, setup table, frame builder
`timescale 1ns/1ps

module touch_core_top (
	input  logic                     i_CLK,
	input  logic                     i_RST,
	input  touch_pkg::host_word_t    i_uart_rx_data,
	input  logic                     i_uart_rx_valid,
	input  logic                     i_uart_tx_ready,
	output touch_pkg::uart_frame_t   o_uart_tx_data,
	output logic                     o_uart_tx_valid,
	input  logic                     i_mpr_init_done,
	input  logic                     i_mpr_busy,
	input  logic                     i_mpr_fail,
	input  touch_pkg::mpr_data_t     i_mpr_rd_data,
	output touch_pkg::mpr_addr_t     o_mpr_reg_addr,
	output touch_pkg::mpr_data_t     o_mpr_wr_data,
	output logic                     o_mpr_wr_en,
	output logic                     o_mpr_rd_en,
	output touch_pkg::touch_status_t o_touch_status,
	output logic                     o_chip_set,
	output logic                     o_run_set,
	output logic                     o_error
);
	import touch_pkg::*;

	// decoder to sequencer
	logic        w_run_mode;
	logic        w_rd_req;
	mpr_addr_t   w_rd_addr;

	// setup table lookup
	init_step_t  w_init_step;
	mpr_addr_t   w_rom_addr;
	mpr_data_t   w_rom_data;

	// sequencer to frame builder
	logic        w_touch_valid;
	logic [15:0] w_status_word;
	logic        w_reg_valid;
	mpr_addr_t   w_reg_addr;
	mpr_data_t   w_reg_data;

	host_cmd_decoder u_decoder (
		.i_CLK      (i_CLK),
		.i_RST      (i_RST),
		.i_rx_data  (i_uart_rx_data),
		.i_rx_valid (i_uart_rx_valid),
		.o_run_mode (w_run_mode),
		.o_rd_req   (w_rd_req),
		.o_rd_addr  (w_rd_addr)
	);

	mpr_config_rom u_rom (
		.i_step (w_init_step),
		.o_addr (w_rom_addr),
		.o_data (w_rom_data)
	);

	mpr_sequencer u_sequencer (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_run_mode      (w_run_mode),
		.i_rd_req        (w_rd_req),
		.i_rd_addr       (w_rd_addr),
		.i_init_done     (i_mpr_init_done),
		.i_busy          (i_mpr_busy),
		.i_fail          (i_mpr_fail),
		.i_rd_data       (i_mpr_rd_data),
		.o_init_step     (w_init_step),
		.i_rom_addr      (w_rom_addr),
		.i_rom_data      (w_rom_data),
		.o_reg_addr      (o_mpr_reg_addr),
		.o_wr_data       (o_mpr_wr_data),
		.o_wr_en         (o_mpr_wr_en),
		.o_rd_en         (o_mpr_rd_en),
		.o_touch_status  (o_touch_status),
		.o_touch_valid   (w_touch_valid),
		.o_status_word   (w_status_word),
		.o_reg_valid     (w_reg_valid),
		.o_reg_addr_echo (w_reg_addr),
		.o_reg_data      (w_reg_data),
		.o_chip_set      (o_chip_set),
		.o_run_set       (o_run_set),
		.o_error         (o_error)
	);

	host_frame_builder u_frame_builder (
		.i_CLK         (i_CLK),
		.i_RST         (i_RST),
		.i_touch_valid (w_touch_valid),
		.i_status_word (w_status_word),
		.i_reg_valid   (w_reg_valid),
		.i_reg_addr    (w_reg_addr),
		.i_reg_data    (w_reg_data),
		.i_tx_ready    (i_uart_tx_ready),
		.o_tx_data     (o_uart_tx_data),
		.o_tx_valid    (o_uart_tx_valid)
	);

endmodule

// ==== rtl/touch_params.svh ====
// command codes, frame tags, MPR121 register map and setup length
`ifndef TOUCH_PARAMS_SVH
`define TOUCH_PARAMS_SVH

// ==================================================
// host command bytes, bits 15:8 of the rx word
// ==================================================
`define CMD_RUN       8'h52 // 'R'
`define CMD_STOP      8'h53 // 'S'
`define CMD_READ_REG  8'h6D // 'm'

// ==================================================
// tag byte leading each outgoing frame
// ==================================================
`define TAG_TOUCH     8'hBB
`define TAG_REG       8'h6D // same byte as the read command

// ==================================================
// MPR121 registers used outside the setup table
// ==================================================
`define MPR_TOUCH0_REG      8'h00 // ELE0..ELE7
`define MPR_TOUCH1_REG      8'h01 // ELE8..ELE11 in low nibble
`define MPR_ELE_CONFIG_REG  8'h5E
`define MPR_ELE_RUN         8'h8F // all 12 electrodes on
`define MPR_ELE_STOP        8'h00 // stop mode

// filter and debounce writes after the engine is up
`define MPR_INIT_COUNT      14

`endif

// ==== rtl/touch_pkg.sv ====
// shared types for the MPR121 front end: bus words, host words, frames, commands
`include "touch_params.svh"

package touch_pkg;

	// ==================================================
	// register access side
	// ==================================================
	typedef logic [7:0] mpr_addr_t;
	typedef logic [7:0] mpr_data_t;

	// index into the setup table, 14 entries
	typedef logic [3:0] init_step_t;

	// ELE0 in bit 0 up to ELE11 in bit 11
	typedef logic [11:0] touch_status_t;

	// ==================================================
	// host side
	// ==================================================
	typedef logic [15:0] host_word_t; // {command, argument}
	typedef logic [79:0] uart_frame_t; // {tag, payload, zero fill}

	typedef enum logic [7:0] {
		HOST_CMD_RUN      = `CMD_RUN,
		HOST_CMD_STOP     = `CMD_STOP,
		HOST_CMD_READ_REG = `CMD_READ_REG
	} host_cmd_e;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the touch core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module touch_core_tb -f list.f -Mdir obj_dir -o touch_core_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/touch_core_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished"
exit 0

// ==== verification/mpr121_bus_model.sv ====
// behavioral MPR121 register-access engine: register file, busy timing, fail injection, write log
`timescale 1ns/1ps

module mpr121_bus_model (
	input  logic                 i_CLK,
	input  logic                 i_RST,
	input  logic                 i_wr_en,
	input  logic                 i_rd_en,
	input  touch_pkg::mpr_addr_t i_addr,
	input  touch_pkg::mpr_data_t i_wr_data,
	input  logic [2:0]           i_busy_len, // 1 to 6 cycles
	input  logic [7:0]           i_fail_at,  // write number to fail, 0 for none
	input  touch_pkg::mpr_data_t i_touch_lo,
	input  touch_pkg::mpr_data_t i_touch_hi,
	output logic                 o_init_done,
	output logic                 o_busy,
	output logic                 o_fail,
	output touch_pkg::mpr_data_t o_rd_data,
	output logic                 o_log_valid,
	output touch_pkg::mpr_addr_t o_log_addr,
	output touch_pkg::mpr_data_t o_log_data
);
	import touch_pkg::*;

	mpr_data_t  regs [256];
	logic [3:0] init_cnt;
	logic [2:0] busy_cnt;
	logic       is_write;
	mpr_addr_t  addr_q;
	mpr_data_t  data_q;
	logic [7:0] write_num; // counts accepted writes since reset

	// power-on contents, odd multiplier so every address differs
	function automatic mpr_data_t fill_value(input mpr_addr_t a);
		return mpr_data_t'((a * 8'd29) ^ 8'h5A);
	endfunction

	always @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			for (int i = 0; i < 256; i++) begin
				regs[i] <= fill_value(8'(i));
			end
			init_cnt    <= '0;
			o_init_done <= 1'b0;
			o_busy      <= 1'b0;
			o_fail      <= 1'b0;
			o_rd_data   <= '0;
			o_log_valid <= 1'b0;
			o_log_addr  <= '0;
			o_log_data  <= '0;
			busy_cnt    <= '0;
			is_write    <= 1'b0;
			addr_q      <= '0;
			data_q      <= '0;
			write_num   <= '0;
		end else begin
			o_log_valid <= 1'b0;
			// engine comes up a few cycles after reset
			if (init_cnt != 4'd10) begin
				init_cnt <= init_cnt + 4'd1;
			end else begin
				o_init_done <= 1'b1;
			end

			if (!o_busy && (i_wr_en || i_rd_en)) begin
				o_busy   <= 1'b1;
				o_fail   <= 1'b0;
				busy_cnt <= i_busy_len;
				is_write <= i_wr_en;
				addr_q   <= i_addr;
				data_q   <= i_wr_data;
				if (i_wr_en) write_num <= write_num + 8'd1;
			end else if (o_busy) begin
				if (busy_cnt > 3'd1) begin
					busy_cnt <= busy_cnt - 3'd1;
				end else begin
					o_busy <= 1'b0; // results valid with busy low
					if (is_write && write_num == i_fail_at) begin
						o_fail <= 1'b1; // injected NAK, register untouched
					end else if (is_write) begin
						regs[addr_q] <= data_q;
						o_log_valid  <= 1'b1;
						o_log_addr   <= addr_q;
						o_log_data   <= data_q;
					end else if (addr_q == 8'h00) begin
						o_rd_data <= i_touch_lo;
					end else if (addr_q == 8'h01) begin
						o_rd_data <= i_touch_hi;
					end else begin
						o_rd_data <= regs[addr_q];
					end
				end
			end
		end
	end

endmodule

// ==== verification/touch_core_tb.sv ====
// testbench for the MPR121 front end: clock, reset, random stimulus, reference checks
`timescale 1ns/1ps
`include "touch_params.svh"

module touch_core_tb;
	import touch_pkg::*;

	localparam int FLAG_CHIP  = 0;
	localparam int FLAG_RUN   = 1;
	localparam int FLAG_ERROR = 2;
	localparam int WAIT_LIMIT = 2000;

	logic          i_CLK;
	logic          i_RST;
	host_word_t    i_uart_rx_data;
	logic          i_uart_rx_valid;
	logic          i_uart_tx_ready = 1'b0;
	uart_frame_t   o_uart_tx_data;
	logic          o_uart_tx_valid;
	logic          i_mpr_init_done;
	logic          i_mpr_busy;
	logic          i_mpr_fail;
	mpr_data_t     i_mpr_rd_data;
	mpr_addr_t     o_mpr_reg_addr;
	mpr_data_t     o_mpr_wr_data;
	logic          o_mpr_wr_en;
	logic          o_mpr_rd_en;
	touch_status_t o_touch_status;
	logic          o_chip_set;
	logic          o_run_set;
	logic          o_error;

	// bus model controls and its write log
	logic [2:0]    busy_len = 3'd1;
	logic [7:0]    fail_at;
	mpr_data_t     touch_lo;
	mpr_data_t     touch_hi;
	logic          log_valid;
	mpr_addr_t     log_addr;
	mpr_data_t     log_data;

	integer        seed = 32'h2564_a078;
	logic [31:0]   rnd_pick = '0;
	logic          ready_en;
	int            en_count = 0;
	mpr_data_t     ref_regs [256];  // mirror of the engine's register file
	uart_frame_t   frame_q [$];
	touch_status_t status_q [$];   // o_touch_status seen with each frame
	logic [15:0]   wr_q [$];       // {addr, data}

	touch_core_top touch_core_top_inst (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_uart_rx_data  (i_uart_rx_data),
		.i_uart_rx_valid (i_uart_rx_valid),
		.i_uart_tx_ready (i_uart_tx_ready),
		.o_uart_tx_data  (o_uart_tx_data),
		.o_uart_tx_valid (o_uart_tx_valid),
		.i_mpr_init_done (i_mpr_init_done),
		.i_mpr_busy      (i_mpr_busy),
		.i_mpr_fail      (i_mpr_fail),
		.i_mpr_rd_data   (i_mpr_rd_data),
		.o_mpr_reg_addr  (o_mpr_reg_addr),
		.o_mpr_wr_data   (o_mpr_wr_data),
		.o_mpr_wr_en     (o_mpr_wr_en),
		.o_mpr_rd_en     (o_mpr_rd_en),
		.o_touch_status  (o_touch_status),
		.o_chip_set      (o_chip_set),
		.o_run_set       (o_run_set),
		.o_error         (o_error)
	);

	mpr121_bus_model bus_model_inst (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_wr_en     (o_mpr_wr_en),
		.i_rd_en     (o_mpr_rd_en),
		.i_addr      (o_mpr_reg_addr),
		.i_wr_data   (o_mpr_wr_data),
		.i_busy_len  (busy_len),
		.i_fail_at   (fail_at),
		.i_touch_lo  (touch_lo),
		.i_touch_hi  (touch_hi),
		.o_init_done (i_mpr_init_done),
		.o_busy      (i_mpr_busy),
		.o_fail      (i_mpr_fail),
		.o_rd_data   (i_mpr_rd_data),
		.o_log_valid (log_valid),
		.o_log_addr  (log_addr),
		.o_log_data  (log_data)
	);

	initial begin
		i_CLK = 1'b0;
		forever #20 i_CLK = ~i_CLK;
	end

	// ==================================================
	// reference rules
	// ==================================================
	function automatic mpr_data_t fill_value(input mpr_addr_t a);
		return mpr_data_t'((a * 8'd29) ^ 8'h5A); // engine power-on contents
	endfunction

	// recommended filter and debounce setup, datasheet order
	function automatic logic [15:0] setup_pair(input int idx);
		case (idx)
			0:       return 16'h2B01;
			1:       return 16'h2C01;
			2:       return 16'h2D0E;
			3:       return 16'h2E00;
			4:       return 16'h2F01;
			5:       return 16'h3005;
			6:       return 16'h3101;
			7:       return 16'h3200;
			8:       return 16'h3300;
			9:       return 16'h3400;
			10:      return 16'h3500;
			11:      return 16'h5B00;
			12:      return 16'h5C10;
			default: return 16'h5D20;
		endcase
	endfunction

	function automatic uart_frame_t touch_frame(input mpr_data_t lo, input mpr_data_t hi);
		return {`TAG_TOUCH, 4'b0000, hi[3:0], lo, 56'b0};
	endfunction

	function automatic logic flag_now(input int sel);
		case (sel)
			FLAG_CHIP: return o_chip_set;
			FLAG_RUN:  return o_run_set;
			default:   return o_error;
		endcase
	endfunction

	// ==================================================
	// reporting and compare tasks
	// ==================================================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_frame(input string name, input uart_frame_t exp, input uart_frame_t act);
		if (exp !== act) begin
			abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_write(input string name, input mpr_addr_t exp_addr,
		input mpr_data_t exp_data, input mpr_addr_t act_addr, input mpr_data_t act_data);
		if (exp_addr !== act_addr || exp_data !== act_data) begin
			abort_run($sformatf("mismatch %s expected %h=%h actual %h=%h",
				name, exp_addr, exp_data, act_addr, act_data));
		end
	endtask

	task automatic check_status(input string name, input touch_status_t exp,
		input touch_status_t act);
		if (exp !== act) begin
			abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			abort_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
		end
	endtask

	// ==================================================
	// stimulus and wait tasks
	// ==================================================
	task automatic apply_reset();
		@(posedge i_CLK);
		i_RST <= 1'b1;
		repeat (4) @(posedge i_CLK);
		i_RST <= 1'b0;
	endtask

	task automatic send_cmd(input logic [7:0] cmd, input logic [7:0] arg);
		@(posedge i_CLK);
		i_uart_rx_data  <= {cmd, arg};
		i_uart_rx_valid <= 1'b1;
		@(posedge i_CLK);
		i_uart_rx_valid <= 1'b0;
	endtask

	// read mid-cycle, clear of the edge update
	task automatic next_random(output logic [31:0] value);
		@(negedge i_CLK);
		value = rnd_pick;
	endtask

	task automatic wait_frame(output uart_frame_t frame, output touch_status_t status);
		int cycles;
		cycles = 0;
		while (frame_q.size() == 0) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run("timeout waiting for a UART frame");
			end else begin
				@(posedge i_CLK);
				cycles++;
			end
		end
		frame  = frame_q.pop_front();
		status = status_q.pop_front();
	endtask

	task automatic wait_write(output mpr_addr_t addr, output mpr_data_t data);
		int          cycles;
		logic [15:0] entry;
		cycles = 0;
		while (wr_q.size() == 0) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run("timeout waiting for a register write on the bus");
			end else begin
				@(posedge i_CLK);
				cycles++;
			end
		end
		entry = wr_q.pop_front();
		addr  = entry[15:8];
		data  = entry[7:0];
	endtask

	task automatic wait_flag(input int sel, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (flag_now(sel) !== level) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run($sformatf("timeout waiting for %s", what));
			end else begin
				@(posedge i_CLK);
				cycles++;
			end
		end
	endtask

	// random ready (about 70%) and busy length, one draw order per edge
	always @(posedge i_CLK) begin
		logic [31:0] r;
		r = $random(seed);
		i_uart_tx_ready <= ready_en && (r[6:0] < 7'd90);
		busy_len        <= 3'd1 + (r[10:8] % 3'd6);
		rnd_pick        <= $random(seed);
	end

	// ==================================================
	// monitors
	// ==================================================
	always @(posedge i_CLK) begin
		if (i_RST) begin
			frame_q.delete();
			status_q.delete();
			wr_q.delete();
			for (int a = 0; a < 256; a++) begin
				ref_regs[a] = fill_value(8'(a));
			end
		end else begin
			if (o_uart_tx_valid && !i_uart_tx_ready) begin
				abort_run("frame valid pulsed while the UART was not ready");
			end
			if (o_uart_tx_valid) begin
				frame_q.push_back(o_uart_tx_data);
				status_q.push_back(o_touch_status);
			end
			if (log_valid) begin
				wr_q.push_back({log_addr, log_data});
				ref_regs[log_addr] = log_data;
			end
			if (o_mpr_wr_en || o_mpr_rd_en) en_count++;
		end
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		uart_frame_t   frame;
		touch_status_t status;
		mpr_addr_t     addr;
		mpr_data_t     data;
		mpr_addr_t     rd_addr;
		logic [15:0]   pair;
		logic [31:0]   rnd;
		int            base;

		i_RST           = 1'b1;
		i_uart_rx_data  = '0;
		i_uart_rx_valid = 1'b0;
		ready_en        = 1'b1;
		fail_at         = 8'd0;
		touch_lo        = 8'h00;
		touch_hi        = 8'h00;
		rnd             = '0;
		apply_reset();

		check_flag("reset chip_set", 1'b0, o_chip_set);
		check_flag("reset run_set", 1'b0, o_run_set);
		check_flag("reset error", 1'b0, o_error);
		check_status("reset status", 12'h000, o_touch_status);

		// setup writes land in table order
		for (int i = 0; i < `MPR_INIT_COUNT; i++) begin
			pair = setup_pair(i);
			wait_write(addr, data);
			check_write("setup write", pair[15:8], pair[7:0], addr, data);
		end
		wait_flag(FLAG_CHIP, 1'b1, "chip_set after setup");
		repeat (20) @(posedge i_CLK);
		if (wr_q.size() != 0) abort_run("extra register write logged after setup");

		send_cmd(`CMD_RUN, 8'h00);
		wait_write(addr, data);
		check_write("run write", `MPR_ELE_CONFIG_REG, `MPR_ELE_RUN, addr, data);
		wait_flag(FLAG_RUN, 1'b1, "run_set after RUN");

		// new touch values per phase, two frames may still carry old or mixed polls
		for (int p = 0; p < 3; p++) begin
			next_random(rnd);
			@(posedge i_CLK);
			touch_lo <= rnd[7:0];
			touch_hi <= rnd[15:8];
			@(posedge i_CLK);
			frame_q.delete();
			status_q.delete();
			repeat (2) wait_frame(frame, status);
			repeat (3) begin
				wait_frame(frame, status);
				check_frame("touch frame", touch_frame(rnd[7:0], rnd[15:8]), frame);
				check_status("touch status", {rnd[11:8], rnd[7:0]}, status);
			end
		end

		// UART held off
		@(posedge i_CLK);
		ready_en <= 1'b0;
		repeat (3) @(posedge i_CLK);
		frame_q.delete();
		status_q.delete();
		repeat (60) @(posedge i_CLK);
		if (frame_q.size() != 0) abort_run("frame sent while the UART was held not ready");
		@(posedge i_CLK);
		ready_en <= 1'b1;
		wait_frame(frame, status);
		check_frame("frame after back-pressure", touch_frame(rnd[7:0], rnd[15:8]), frame);

		send_cmd(`CMD_STOP, 8'h00);
		wait_write(addr, data);
		check_write("stop write", `MPR_ELE_CONFIG_REG, `MPR_ELE_STOP, addr, data);
		wait_flag(FLAG_RUN, 1'b0, "run_set to clear after STOP");
		repeat (30) @(posedge i_CLK); // last pending frame leaves
		frame_q.delete();
		status_q.delete();
		repeat (100) @(posedge i_CLK);
		if (frame_q.size() != 0) abort_run("touch frame sent after STOP");

		// register reads while stopped, 0x02 to 0x7F
		for (int k = 0; k < 3; k++) begin
			next_random(rnd);
			rd_addr = 8'h02 + mpr_addr_t'(rnd[6:0] % 7'd126);
			send_cmd(`CMD_READ_REG, rd_addr);
			wait_frame(frame, status);
			check_frame("register frame", {`TAG_REG, rd_addr, ref_regs[rd_addr], 56'b0}, frame);
		end

		// third setup write refused by the engine
		fail_at <= 8'd3;
		apply_reset();
		wait_flag(FLAG_ERROR, 1'b1, "error after the failed setup write");
		check_flag("chip_set after fail", 1'b0, o_chip_set);
		base = en_count;
		repeat (200) @(posedge i_CLK);
		if (en_count != base) abort_run("bus enable strobe seen after the error");
		check_flag("chip_set held after fail", 1'b0, o_chip_set);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
